// File: alu/alu_exec.sv
`timescale 1ns/1ps

module alu_exec (
    input  logic                clk,
    input  logic                rst_n,
    input  alu_pkg::alu_op_t    alu_op_i,
    input  alu_pkg::xlen_t      src1_i,
    input  alu_pkg::xlen_t      src2_i,
    input  logic                md_en_i,
    input  alu_pkg::md_sel_t    md_sel_i,
    input  logic                flush_i,
    muldiv_if.requester         mul_bus,
    muldiv_if.requester         div_bus,
    output alu_pkg::xlen_t      result_o,
    output logic                less_o,
    output logic                zero_o,
    output logic                busy_o
);
    import alu_pkg::*;

    alu_fn_e fn;
    logic    variant;
    logic    word;
    logic    cin;
    xlen_t   src2_x;
    xlen_t   sum;
    logic    carry;
    logic    overflow;
    logic    less;
    xlen_t   shift;
    xlen_t   alu_out;
    xlen_t   md_out;
    xlen_t   sel_out;

    // launch latch and pending state
    xlen_t   src1_q;
    xlen_t   src2_q;
    md_sel_t sel_q;
    logic    vld_q;
    logic    pending_q;
    logic    diff_in;
    logic    launch;
    logic    done_sel;

    assign fn      = alu_fn_e'(alu_op_i[2:0]);
    assign variant = alu_op_i[3];
    assign word    = alu_op_i[4];

    // slt always subtracts, add subtracts on the variant bit
    assign cin    = variant | (fn == FN_SLT);
    assign src2_x = src2_i ^ {XLEN{cin}};

    assign {carry, sum} = {1'b0, src1_i} + {1'b0, src2_x} + {{XLEN{1'b0}}, cin};
    assign overflow     = (src1_i[XLEN-1] == src2_x[XLEN-1]) && (sum[XLEN-1] != src1_i[XLEN-1]);

    // unsigned compare from the borrow, signed from sign and overflow
    assign less = variant ? (carry ^ cin) : (sum[XLEN-1] ^ overflow);

    alu_shifter u_alu_shifter (
        .src_i   (src1_i),
        .shamt_i (src2_i[5:0]),
        .right_i (alu_op_i[2]),
        .arith_i (variant),
        .word_i  (word),
        .shift_o (shift)
    );

    always_comb begin
        case (fn)
            FN_ADD:         alu_out = sum;
            FN_SLL, FN_SR:  alu_out = shift;
            FN_SLT:         alu_out = {{(XLEN-1){1'b0}}, less};
            FN_SRC2:        alu_out = src2_i;
            FN_XOR:         alu_out = src1_i ^ src2_i;
            FN_OR:          alu_out = src1_i | src2_i;
            FN_AND:         alu_out = src1_i & src2_i;
            default:        alu_out = sum;
        endcase
    end

    assign md_out  = md_sel_i[2] ? div_bus.result : mul_bus.result;
    assign sel_out = md_en_i ? md_out : alu_out;

    // word ops keep the low half, sign extended
    assign result_o = word ? {{32{sel_out[31]}}, sel_out[31:0]} : sel_out;
    assign less_o   = less;
    assign zero_o   = ~(|sum);

    // new request when anything differs from the last launch
    assign diff_in = !vld_q || (src1_i != src1_q) || (src2_i != src2_q) || (md_sel_i != sel_q);
    assign launch  = md_en_i && diff_in && !pending_q && !flush_i;

    assign done_sel = sel_q[2] ? div_bus.done : mul_bus.done;

    always_ff @(posedge clk) begin
        if (launch) begin
            src1_q <= src1_i;
            src2_q <= src2_i;
            sel_q  <= md_sel_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q     <= 1'b0;
            pending_q <= 1'b0;
        end else if (flush_i) begin
            vld_q     <= 1'b0;
            pending_q <= 1'b0;
        end else if (launch) begin
            vld_q     <= 1'b1;
            pending_q <= 1'b1;
        end else if (pending_q && done_sel) begin
            pending_q <= 1'b0;
        end
    end

    assign busy_o = md_en_i && (launch || pending_q);

    // both units see the same operands, only one gets the start
    assign mul_bus.start   = launch && !md_sel_i[2];
    assign mul_bus.flush   = flush_i;
    assign mul_bus.md_type = md_sel_i[1:0];
    assign mul_bus.op_a    = src1_i;
    assign mul_bus.op_b    = src2_i;

    assign div_bus.start   = launch && md_sel_i[2];
    assign div_bus.flush   = flush_i;
    assign div_bus.md_type = md_sel_i[1:0];
    assign div_bus.op_a    = src1_i;
    assign div_bus.op_b    = src2_i;

endmodule

// File: alu/alu_shifter.sv
`timescale 1ns/1ps

module alu_shifter (
    input  alu_pkg::xlen_t  src_i,
    input  alu_pkg::shamt_t shamt_i,
    input  logic            right_i,
    input  logic            arith_i,
    input  logic            word_i,
    output alu_pkg::xlen_t  shift_o
);
    import alu_pkg::*;

    function automatic xlen_t bit_rev(input xlen_t v);
        xlen_t r;
        for (int i = 0; i < XLEN; i++) begin
            r[i] = v[XLEN-1-i];
        end
        return r;
    endfunction

    shamt_t amt;
    xlen_t  shft_src;
    xlen_t  shft_res;
    xlen_t  lo_mask;
    xlen_t  word_mask;
    xlen_t  srl_res;
    xlen_t  sra_res;

    // word shifts only use five bits of the amount
    assign amt = word_i ? {1'b0, shamt_i[4:0]} : shamt_i;

    // left shifts go through the right shifter on reversed bits
    assign shft_src = right_i ? src_i : bit_rev(src_i);
    assign shft_res = shft_src >> amt;

    // ones where shifted data remains
    assign lo_mask   = {XLEN{1'b1}} >> amt;
    assign word_mask = {32'h0, lo_mask[XLEN-1:32]};

    always_comb begin
        if (word_i) begin
            srl_res = shft_res & word_mask;
            // fill from bit 31 for word arithmetic shifts
            sra_res = src_i[31] ? (shft_res | ~word_mask) : (shft_res & word_mask);
        end else begin
            srl_res = shft_res;
            sra_res = shft_res | ({XLEN{src_i[XLEN-1]}} & ~lo_mask);
        end
    end

    assign shift_o = !right_i ? bit_rev(shft_res) :
                     arith_i  ? sra_res : srl_res;

endmodule

// File: common/alu_pkg.sv
package alu_pkg;

    // datapath width
    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;

    // bit 4 word mode, bit 3 variant, bits 2:0 function
    typedef logic [4:0] alu_op_t;

    typedef enum logic [2:0] {
        FN_ADD  = 3'b000,
        FN_SLL  = 3'b001,
        FN_SLT  = 3'b010,
        FN_SRC2 = 3'b011,
        FN_XOR  = 3'b100,
        FN_SR   = 3'b101,
        FN_OR   = 3'b110,
        FN_AND  = 3'b111
    } alu_fn_e;

    // bit 2 picks the divider, bits 1:0 the variant
    typedef logic [2:0] md_sel_t;
    typedef logic [1:0] md_type_t;

    // multiply variants
    localparam md_type_t MUL    = 2'b00;
    localparam md_type_t MULH   = 2'b01;
    localparam md_type_t MULHSU = 2'b10;
    localparam md_type_t MULHU  = 2'b11;

    // divide variants
    localparam md_type_t DIV  = 2'b00;
    localparam md_type_t DIVU = 2'b01;
    localparam md_type_t REM  = 2'b10;
    localparam md_type_t REMU = 2'b11;

    typedef logic [5:0] shamt_t;

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        RUN  = 2'b01,
        DONE = 2'b10
    } md_state_e;

    // one result bit per iteration
    localparam int MUL_STEPS = 64;
    localparam int DIV_STEPS = 64;

endpackage

// File: common/muldiv_if.sv
`timescale 1ns/1ps

interface muldiv_if;
    import alu_pkg::*;

    logic     start;
    logic     flush;
    md_type_t md_type;
    xlen_t    op_a;
    xlen_t    op_b;
    logic     done;
    xlen_t    result;

    // execute block side
    modport requester (
        output start, flush, md_type, op_a, op_b,
        input  done, result
    );

    // multiplier or divider side
    modport unit (
        input  start, flush, md_type, op_a, op_b,
        output done, result
    );

endinterface

// File: muldiv/muldiv_div.sv
`timescale 1ns/1ps

module muldiv_div (
    input  logic     clk,
    input  logic     rst_n,
    muldiv_if.unit   md
);
    import alu_pkg::*;

    md_state_e      state_q;
    logic [6:0]     cnt_q;
    xlen_t          rem_q;
    xlen_t          quo_q;
    xlen_t          dsr_q;
    logic           neg_quo_q;
    logic           neg_rem_q;
    logic           rem_sel_q;
    xlen_t          result_q;

    logic           sgn;
    logic           is_rem;
    logic           a_neg;
    logic           b_neg;
    xlen_t          mag_a;
    xlen_t          mag_b;
    logic           b_zero;
    logic           ovf;
    logic           special;
    logic [XLEN:0]  trial;
    xlen_t          quo_f;
    xlen_t          rem_f;
    logic           last;

    always_comb begin
        case (md.md_type)
            DIV:     {sgn, is_rem} = 2'b10;
            DIVU:    {sgn, is_rem} = 2'b00;
            REM:     {sgn, is_rem} = 2'b11;
            REMU:    {sgn, is_rem} = 2'b01;
            default: {sgn, is_rem} = 2'b00;
        endcase
    end

    assign a_neg = sgn && md.op_a[XLEN-1];
    assign b_neg = sgn && md.op_b[XLEN-1];
    assign mag_a = a_neg ? -md.op_a : md.op_a;
    assign mag_b = b_neg ? -md.op_b : md.op_b;

    // cases resolved at start without iterating
    assign b_zero  = (md.op_b == '0);
    assign ovf     = sgn && (md.op_a == {1'b1, {(XLEN-1){1'b0}}}) && (md.op_b == '1);
    assign special = b_zero || ovf;

    // restoring step subtracts only when it does not borrow
    assign trial = {rem_q, quo_q[XLEN-1]} - {1'b0, dsr_q};

    assign quo_f = neg_quo_q ? -quo_q : quo_q;
    assign rem_f = neg_rem_q ? -rem_q : rem_q;
    assign last  = (cnt_q == 7'(DIV_STEPS));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else if (md.flush) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else if (md.start) begin
            state_q <= special ? DONE : RUN;
            cnt_q   <= '0;
        end else if (state_q == RUN) begin
            cnt_q <= cnt_q + 7'd1;
            if (last) begin
                state_q <= DONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (md.start) begin
            rem_q     <= '0;
            quo_q     <= mag_a;
            dsr_q     <= mag_b;
            // remainder takes the sign of the dividend
            neg_quo_q <= a_neg ^ b_neg;
            neg_rem_q <= a_neg;
            rem_sel_q <= is_rem;
            if (b_zero) begin
                result_q <= is_rem ? md.op_a : '1;
            end else if (ovf) begin
                result_q <= is_rem ? '0 : md.op_a;
            end
        end else if (state_q == RUN) begin
            if (last) begin
                result_q <= rem_sel_q ? rem_f : quo_f;
            end else if (!trial[XLEN]) begin
                rem_q <= trial[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= {rem_q[XLEN-2:0], quo_q[XLEN-1]};
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    assign md.done   = (state_q == DONE);
    assign md.result = result_q;

endmodule

// File: muldiv/muldiv_mul.sv
`timescale 1ns/1ps

module muldiv_mul (
    input  logic     clk,
    input  logic     rst_n,
    muldiv_if.unit   md
);
    import alu_pkg::*;

    md_state_e          state_q;
    logic [6:0]         cnt_q;
    logic [2*XLEN-1:0]  prod_q;
    xlen_t              mcand_q;
    logic               neg_q;
    md_type_t           type_q;
    xlen_t              result_q;

    logic               a_sgn;
    logic               b_sgn;
    logic               a_neg;
    logic               b_neg;
    xlen_t              mag_a;
    xlen_t              mag_b;
    logic [XLEN:0]      step_sum;
    logic [2*XLEN-1:0]  full;
    logic               last;

    // which operands are signed
    always_comb begin
        case (md.md_type)
            MUL:     {a_sgn, b_sgn} = 2'b00;
            MULH:    {a_sgn, b_sgn} = 2'b11;
            MULHSU:  {a_sgn, b_sgn} = 2'b10;
            MULHU:   {a_sgn, b_sgn} = 2'b00;
            default: {a_sgn, b_sgn} = 2'b00;
        endcase
    end

    assign a_neg = a_sgn && md.op_a[XLEN-1];
    assign b_neg = b_sgn && md.op_b[XLEN-1];
    assign mag_a = a_neg ? -md.op_a : md.op_a;
    assign mag_b = b_neg ? -md.op_b : md.op_b;

    // add multiplicand to upper half when the low bit is set
    assign step_sum = {1'b0, prod_q[2*XLEN-1:XLEN]} + (prod_q[0] ? {1'b0, mcand_q} : '0);

    assign full = neg_q ? -prod_q : prod_q;
    assign last = (cnt_q == 7'(MUL_STEPS));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else if (md.flush) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else if (md.start) begin
            state_q <= RUN;
            cnt_q   <= '0;
        end else if (state_q == RUN) begin
            cnt_q <= cnt_q + 7'd1;
            if (last) begin
                state_q <= DONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (md.start) begin
            prod_q  <= {{XLEN{1'b0}}, mag_b};
            mcand_q <= mag_a;
            neg_q   <= a_neg ^ b_neg;
            type_q  <= md.md_type;
        end else if (state_q == RUN) begin
            if (last) begin
                result_q <= (type_q == MUL) ? full[XLEN-1:0] : full[2*XLEN-1:XLEN];
            end else begin
                prod_q <= {step_sum, prod_q[XLEN-1:1]};
            end
        end
    end

    assign md.done   = (state_q == DONE);
    assign md.result = result_q;

endmodule

// File: source/alu_top.sv
`timescale 1ns/1ps

module alu_top (
    input  logic                clk,
    input  logic                rst_n,
    input  alu_pkg::alu_op_t    alu_op_i,
    input  alu_pkg::xlen_t      src1_i,
    input  alu_pkg::xlen_t      src2_i,
    input  logic                md_en_i,
    input  alu_pkg::md_sel_t    md_sel_i,
    input  logic                flush_i,
    output alu_pkg::xlen_t      result_o,
    output logic                less_o,
    output logic                zero_o,
    output logic                busy_o
);

    // one link per unit
    muldiv_if mul_bus ();
    muldiv_if div_bus ();

    alu_exec u_alu_exec (
        .clk      (clk),
        .rst_n    (rst_n),
        .alu_op_i (alu_op_i),
        .src1_i   (src1_i),
        .src2_i   (src2_i),
        .md_en_i  (md_en_i),
        .md_sel_i (md_sel_i),
        .flush_i  (flush_i),
        .mul_bus  (mul_bus),
        .div_bus  (div_bus),
        .result_o (result_o),
        .less_o   (less_o),
        .zero_o   (zero_o),
        .busy_o   (busy_o)
    );

    muldiv_mul u_muldiv_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .md    (mul_bus)
    );

    muldiv_div u_muldiv_div (
        .clk   (clk),
        .rst_n (rst_n),
        .md    (div_bus)
    );

endmodule

// File: testbench/alu_exec_chk.sv
`timescale 1ns/1ps

module alu_exec_chk (
    input logic clk,
    input logic rst_n,
    input logic md_en_i,
    input logic flush_i,
    input logic busy_i,
    input logic mul_start_i,
    input logic div_start_i,
    input logic mul_done_i,
    input logic div_done_i
);

    logic mul_req_q;
    logic div_req_q;
    logic any_start;

    assign any_start = mul_start_i || div_start_i;

    // outstanding request per unit as seen on the links
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_req_q <= 1'b0;
            div_req_q <= 1'b0;
        end else if (flush_i) begin
            mul_req_q <= 1'b0;
            div_req_q <= 1'b0;
        end else begin
            if (mul_start_i) begin
                mul_req_q <= 1'b1;
            end else if (mul_done_i) begin
                mul_req_q <= 1'b0;
            end
            if (div_start_i) begin
                div_req_q <= 1'b1;
            end else if (div_done_i) begin
                div_req_q <= 1'b0;
            end
        end
    end

    // a new start would overwrite an outstanding result
    start_not_pending: assert property (@(posedge clk) disable iff (!rst_n)
        any_start |-> (!mul_req_q && !div_req_q))
        else $error("start issued while a result is pending");

    start_needs_enable: assert property (@(posedge clk) disable iff (!rst_n)
        any_start |-> md_en_i)
        else $error("start issued without md_en_i");

    // after a flush only a fresh launch may keep busy high
    flush_clears_busy: assert property (@(posedge clk) disable iff (!rst_n)
        flush_i |=> ((any_start == (md_en_i && !flush_i)) && (busy_i == any_start)))
        else $error("busy_o or start wrong in the cycle after a flush");

    one_unit_started: assert property (@(posedge clk) disable iff (!rst_n)
        !(mul_start_i && div_start_i))
        else $error("multiplier and divider started together");

endmodule

bind alu_exec alu_exec_chk u_alu_exec_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .md_en_i     (md_en_i),
    .flush_i     (flush_i),
    .busy_i      (busy_o),
    .mul_start_i (mul_bus.start),
    .div_start_i (div_bus.start),
    .mul_done_i  (mul_bus.done),
    .div_done_i  (div_bus.done)
);

// File: testbench/alu_tb.sv
`timescale 1ns/1ps

module alu_tb;
    import alu_pkg::*;

    localparam int NUM_DIR  = 52;
    localparam int NUM_RAND = 20;
    localparam int MAX_WAIT = 200;

    // bit 4 word, bit 3 variant, bits 2:0 function
    localparam alu_op_t OP_ADD  = {2'b00, FN_ADD};
    localparam alu_op_t OP_SUB  = {2'b01, FN_ADD};
    localparam alu_op_t OP_SLL  = {2'b00, FN_SLL};
    localparam alu_op_t OP_SLT  = {2'b00, FN_SLT};
    localparam alu_op_t OP_SLTU = {2'b01, FN_SLT};
    localparam alu_op_t OP_SRC2 = {2'b00, FN_SRC2};
    localparam alu_op_t OP_XOR  = {2'b00, FN_XOR};
    localparam alu_op_t OP_SRL  = {2'b00, FN_SR};
    localparam alu_op_t OP_SRA  = {2'b01, FN_SR};
    localparam alu_op_t OP_OR   = {2'b00, FN_OR};
    localparam alu_op_t OP_AND  = {2'b00, FN_AND};
    localparam alu_op_t OP_ADDW = {2'b10, FN_ADD};
    localparam alu_op_t OP_SLLW = {2'b10, FN_SLL};
    localparam alu_op_t OP_SRLW = {2'b10, FN_SR};
    localparam alu_op_t OP_SRAW = {2'b11, FN_SR};

    localparam xlen_t MIN_NEG = 64'h8000_0000_0000_0000;
    localparam xlen_t ONES    = 64'hFFFF_FFFF_FFFF_FFFF;
    localparam xlen_t NEG7    = 64'hFFFF_FFFF_FFFF_FFF9;
    localparam xlen_t PAT_A   = 64'hF00F_1234_8765_ABCD;
    localparam xlen_t PAT_B   = 64'h0FF0_A5A5_3C3C_9999;

    localparam alu_op_t RAND_OPS [8] = '{OP_ADD, OP_SUB, OP_XOR, OP_OR,
                                         OP_AND, OP_SLT, OP_SLTU, OP_SRA};

    typedef struct packed {
        alu_op_t    op;
        md_sel_t    sel;
        logic       md;
        xlen_t      a;
        xlen_t      b;
        logic [7:0] flush_at;
    } vec_t;

    // op, sel, md_en, src1, src2, flush cycle (0 = none)
    localparam vec_t DIR_TBL [NUM_DIR] = '{
        '{OP_ADD,  3'd0, 1'b0, 64'd5,   64'd7,  8'd0},
        '{OP_ADD,  3'd0, 1'b0, ONES,    64'd1,  8'd0},
        '{OP_SUB,  3'd0, 1'b0, 64'd100, 64'd100, 8'd0},
        '{OP_SUB,  3'd0, 1'b0, 64'd3,   64'd10, 8'd0},
        '{OP_XOR,  3'd0, 1'b0, PAT_A,   PAT_B,  8'd0},
        '{OP_OR,   3'd0, 1'b0, PAT_A,   PAT_B,  8'd0},
        '{OP_AND,  3'd0, 1'b0, PAT_A,   PAT_B,  8'd0},
        '{OP_SRC2, 3'd0, 1'b0, PAT_A,   PAT_B,  8'd0},
        '{OP_SLT,  3'd0, 1'b0, MIN_NEG, ONES,   8'd0},
        '{OP_SLTU, 3'd0, 1'b0, MIN_NEG, ONES,   8'd0},
        '{OP_SLT,  3'd0, 1'b0, ONES,    MIN_NEG, 8'd0},
        '{OP_SLTU, 3'd0, 1'b0, ONES,    MIN_NEG, 8'd0},
        '{OP_SLT,  3'd0, 1'b0, ONES,    64'd0,  8'd0},
        '{OP_SLTU, 3'd0, 1'b0, ONES,    64'd0,  8'd0},
        '{OP_SLT,  3'd0, 1'b0, 64'd42,  64'd42, 8'd0},
        '{OP_SLTU, 3'd0, 1'b0, 64'd42,  64'd42, 8'd0},
        '{OP_SLL,  3'd0, 1'b0, PAT_A,   64'd0,  8'd0},
        '{OP_SLL,  3'd0, 1'b0, PAT_A,   64'd1,  8'd0},
        '{OP_SLL,  3'd0, 1'b0, PAT_A,   64'd31, 8'd0},
        '{OP_SLL,  3'd0, 1'b0, PAT_A,   64'd32, 8'd0},
        '{OP_SLL,  3'd0, 1'b0, PAT_A,   64'd63, 8'd0},
        '{OP_SRL,  3'd0, 1'b0, PAT_A,   64'd0,  8'd0},
        '{OP_SRL,  3'd0, 1'b0, PAT_A,   64'd1,  8'd0},
        '{OP_SRL,  3'd0, 1'b0, PAT_A,   64'd31, 8'd0},
        '{OP_SRL,  3'd0, 1'b0, PAT_A,   64'd32, 8'd0},
        '{OP_SRL,  3'd0, 1'b0, PAT_A,   64'd63, 8'd0},
        '{OP_SRA,  3'd0, 1'b0, PAT_A,   64'd0,  8'd0},
        '{OP_SRA,  3'd0, 1'b0, PAT_A,   64'd1,  8'd0},
        '{OP_SRA,  3'd0, 1'b0, PAT_A,   64'd31, 8'd0},
        '{OP_SRA,  3'd0, 1'b0, PAT_A,   64'd32, 8'd0},
        '{OP_SRA,  3'd0, 1'b0, PAT_A,   64'd63, 8'd0},
        '{OP_SRLW, 3'd0, 1'b0, PAT_A,   64'd4,  8'd0},
        '{OP_SRAW, 3'd0, 1'b0, PAT_A,   64'd4,  8'd0},
        '{OP_SRAW, 3'd0, 1'b0, PAT_A,   64'd0,  8'd0},
        '{OP_SLLW, 3'd0, 1'b0, PAT_A,   64'd1,  8'd0},
        '{OP_ADDW, 3'd0, 1'b0, 64'h7FFF_FFFF, 64'd1, 8'd0},
        '{OP_ADD, {1'b0, MUL},    1'b1, MIN_NEG, ONES,    8'd0},
        '{OP_ADD, {1'b0, MULH},   1'b1, MIN_NEG, MIN_NEG, 8'd0},
        '{OP_ADD, {1'b0, MULHSU}, 1'b1, ONES,    ONES,    8'd0},
        '{OP_ADD, {1'b0, MULHU},  1'b1, ONES,    ONES,    8'd0},
        '{OP_ADD, {1'b0, MUL},    1'b1, 64'd123456789, 64'd987654321, 8'd0},
        '{OP_ADD, {1'b0, MULH},   1'b1, ONES,    64'd7,   8'd0},
        '{OP_ADD, {1'b1, DIV},    1'b1, NEG7,    64'd2,   8'd0},
        '{OP_ADD, {1'b1, DIVU},   1'b1, 64'd100, 64'd7,   8'd0},
        '{OP_ADD, {1'b1, REM},    1'b1, NEG7,    64'd2,   8'd0},
        '{OP_ADD, {1'b1, REMU},   1'b1, 64'd100, 64'd7,   8'd0},
        '{OP_ADD, {1'b1, DIV},    1'b1, 64'd17,  64'd0,   8'd0},
        '{OP_ADD, {1'b1, REMU},   1'b1, 64'd17,  64'd0,   8'd0},
        '{OP_ADD, {1'b1, DIV},    1'b1, MIN_NEG, ONES,    8'd0},
        '{OP_ADD, {1'b1, REM},    1'b1, MIN_NEG, ONES,    8'd0},
        '{OP_ADD, {1'b1, DIVU},   1'b1, MIN_NEG, ONES,    8'd0},
        '{OP_ADD, {1'b1, DIV},    1'b1, PAT_A,   64'd3,   8'd20}
    };

    logic        clk = 1'b0;
    logic        rst_n;
    alu_op_t     alu_op;
    xlen_t       src1;
    xlen_t       src2;
    logic        md_en;
    md_sel_t     md_sel;
    logic        flush;
    xlen_t       result;
    logic        less;
    logic        zero;
    logic        busy;
    logic [31:0] seed;
    vec_t        vecs [$];

    always #50 clk = ~clk;

    alu_top u_alu_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .alu_op_i (alu_op),
        .src1_i   (src1),
        .src2_i   (src2),
        .md_en_i  (md_en),
        .md_sel_i (md_sel),
        .flush_i  (flush),
        .result_o (result),
        .less_o   (less),
        .zero_o   (zero),
        .busy_o   (busy)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_word(output xlen_t w);
        seed = lcg_step(seed);
        w[63:32] = seed;
        seed = lcg_step(seed);
        w[31:0] = seed;
    endtask

    function automatic logic ref_less(input alu_op_t op, input xlen_t a, input xlen_t b);
        if (op[3]) begin
            return a < b;
        end
        return $signed(a) < $signed(b);
    endfunction

    // adder subtracts for the variant bit and for slt
    function automatic logic ref_zero(input alu_op_t op, input xlen_t a, input xlen_t b);
        xlen_t s;
        s = (op[3] || op[2:0] == FN_SLT) ? a - b : a + b;
        return s == '0;
    endfunction

    function automatic xlen_t ref_alu(input alu_op_t op, input xlen_t a, input xlen_t b);
        xlen_t       r;
        logic [31:0] lo;
        case (op[2:0])
            FN_ADD:  r = op[3] ? a - b : a + b;
            FN_SLL:  r = op[4] ? a << b[4:0] : a << b[5:0];
            FN_SLT:  r = {63'd0, ref_less(op, a, b)};
            FN_SRC2: r = b;
            FN_XOR:  r = a ^ b;
            FN_OR:   r = a | b;
            FN_AND:  r = a & b;
            default: begin
                if (op[4]) begin
                    if (op[3]) begin
                        lo = $signed(a[31:0]) >>> b[4:0];
                    end else begin
                        lo = a[31:0] >> b[4:0];
                    end
                    r = {32'd0, lo};
                end else if (op[3]) begin
                    r = $signed(a) >>> b[5:0];
                end else begin
                    r = a >> b[5:0];
                end
            end
        endcase
        if (op[4]) begin
            r = {{32{r[31]}}, r[31:0]};
        end
        return r;
    endfunction

    function automatic xlen_t ref_muldiv(input md_sel_t sel, input xlen_t a, input xlen_t b);
        logic [127:0] ea;
        logic [127:0] eb;
        logic [127:0] p;
        logic         sgn;
        xlen_t        q;
        xlen_t        r;
        if (!sel[2]) begin
            ea = (sel[1:0] == MULH || sel[1:0] == MULHSU) ? {{64{a[63]}}, a} : {64'd0, a};
            eb = (sel[1:0] == MULH) ? {{64{b[63]}}, b} : {64'd0, b};
            p  = ea * eb;
            return (sel[1:0] == MUL) ? p[63:0] : p[127:64];
        end
        sgn = (sel[1:0] == DIV) || (sel[1:0] == REM);
        if (b == '0) begin
            q = ONES;
            r = a;
        end else if (sgn && a == MIN_NEG && b == ONES) begin
            q = a;
            r = '0;
        end else if (sgn) begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        return (sel[1:0] == REM || sel[1:0] == REMU) ? r : q;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input xlen_t got, input xlen_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s got %h expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s got %b expected %b",
                                $time, what, got, exp));
        end
    endtask

    // entered on a falling edge and left on the first falling edge with busy low
    task automatic wait_idle(input string what);
        int n;
        n = 0;
        while (busy !== 1'b0 && n < MAX_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (busy !== 1'b0) begin
            abort_run($sformatf("timeout: busy_o still high after %0d cycles during %s",
                                MAX_WAIT, what));
        end
    endtask

    task automatic apply_vec(input vec_t v);
        @(posedge clk);
        alu_op <= v.op;
        src1   <= v.a;
        src2   <= v.b;
        md_sel <= v.sel;
        md_en  <= v.md;
        flush  <= 1'b0;
        @(negedge clk);
        if (!v.md) begin
            check_data(result, ref_alu(v.op, v.a, v.b), "alu result");
            check_flag(zero, ref_zero(v.op, v.a, v.b), "zero flag");
            if (v.op[2:0] == FN_SLT) begin
                check_flag(less, ref_less(v.op, v.a, v.b), "less flag");
            end
            check_flag(busy, 1'b0, "busy without md_en");
        end else begin
            check_flag(busy, 1'b1, "busy at launch");
            if (v.flush_at != 8'd0) begin
                for (int k = 0; k < v.flush_at; k++) begin
                    @(negedge clk);
                    check_flag(busy, 1'b1, "busy before flush");
                end
                @(posedge clk);
                flush <= 1'b1;
                @(negedge clk);
                check_flag(busy, 1'b1, "busy during flush");
                @(posedge clk);
                flush <= 1'b0;
                @(negedge clk);
                check_flag(busy, 1'b1, "busy at relaunch");
            end
            wait_idle("muldiv");
            check_data(result, ref_muldiv(v.sel, v.a, v.b), "muldiv result");
        end
    endtask

    initial begin
        vec_t  v;
        xlen_t rnd;
        rst_n  = 1'b0;
        alu_op = '0;
        src1   = '0;
        src2   = '0;
        md_en  = 1'b0;
        md_sel = '0;
        flush  = 1'b0;
        seed   = 32'h8643;

        for (int i = 0; i < NUM_DIR; i++) begin
            vecs.push_back(DIR_TBL[i]);
        end
        // random operands with every fifth one a multiply or divide
        for (int i = 0; i < NUM_RAND; i++) begin
            next_word(v.a);
            next_word(v.b);
            next_word(rnd);
            v.md       = (i % 5 == 4);
            v.sel      = rnd[2:0];
            v.op       = v.md ? OP_ADD : RAND_OPS[rnd[5:3]];
            v.flush_at = 8'd0;
            vecs.push_back(v);
        end

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag(busy, 1'b0, "busy after reset");

        foreach (vecs[i]) begin
            apply_vec(vecs[i]);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: verilog.f
common/alu_pkg.sv
common/muldiv_if.sv
alu/alu_shifter.sv
alu/alu_exec.sv
muldiv/muldiv_mul.sv
muldiv/muldiv_div.sv
source/alu_top.sv
testbench/alu_exec_chk.sv
testbench/alu_tb.sv
